// File: ifu_defines.svh
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// word width, also the fetch address width
`define IFU_XLEN 32

// compressed parcel width
`define IFU_HALF 16

// width of the trap bus toward the trap unit
`define IFU_TRAP_LEN 16

// bit positions on the trap bus
// these follow the mcause exception codes
`define IFU_TRAP_INST_MISALIGNED 0
`define IFU_TRAP_INST_ACCESS_FAULT 1
`define IFU_TRAP_INST_PAGE_FAULT 12

// addi x0, x0, 0
// sent whenever no instruction is ready
`define IFU_NOP 32'h0000_0013

`endif

// File: ifu_types_pkg.sv
`include "ifu_defines.svh"

package ifu_types_pkg;

    // fetch word returned by the instruction memory
    // valid is a single-cycle strobe for the current pc
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] rdata;
    } imem_rsp_t;

    // translation response
    // page_fault only counts while valid is high
    typedef struct packed {
        logic valid;
        logic page_fault;
    } xlat_rsp_t;

    // aligned instruction toward decode
    typedef struct packed {
        logic [`IFU_XLEN-1:0] addr;
        logic [`IFU_XLEN-1:0] inst;
        // set when inst came out of the rvc expander
        logic                 is_compressed;
    } fetch_out_t;

    // translation wait sequencer
    typedef enum logic [1:0] {
        // nothing outstanding
        XLAT_IDLE      = 2'b00,
        // translation requested, waiting on its strobe
        XLAT_WAIT_XLAT = 2'b01,
        // translation done, waiting on the fetch word
        XLAT_WAIT_MEM  = 2'b10
    } xlat_state_e;

endpackage

// File: ifu_trap_pkg.sv
`include "ifu_defines.svh"

package ifu_trap_pkg;

    // one bit per exception cause
    typedef logic [`IFU_TRAP_LEN-1:0] trap_bus_t;

    // causes the fetch stage can raise
    // values double as bit indices on trap_bus_t
    typedef enum logic [3:0] {
        CAUSE_INST_MISALIGNED   = 4'(`IFU_TRAP_INST_MISALIGNED),
        CAUSE_INST_ACCESS_FAULT = 4'(`IFU_TRAP_INST_ACCESS_FAULT),
        CAUSE_INST_PAGE_FAULT   = 4'(`IFU_TRAP_INST_PAGE_FAULT)
    } trap_cause_e;

endpackage

// File: rvc_expander.sv
`timescale 1ns/10ps
`include "ifu_defines.svh"

module rvc_expander (
    input  logic [`IFU_HALF-1:0] half_i,
    output logic [`IFU_XLEN-1:0] inst_o
);

    // full register fields
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    // popular registers x8..x15
    logic [4:0]  rd_prime;
    logic [4:0]  rs1_prime;
    // ci immediate, sign extended to 12 bits
    logic [11:0] ci_imm;
    // lw / sw word offset, zero extended
    logic [11:0] mem_off;
    // c.j offset, sign extended, bit 0 always zero
    logic [20:0] j_off;

    assign rd_full   = half_i[11:7];
    assign rs2_full  = half_i[6:2];
    assign rd_prime  = {2'b01, half_i[4:2]};
    assign rs1_prime = {2'b01, half_i[9:7]};

    assign ci_imm  = {{6{half_i[12]}}, half_i[12], half_i[6:2]};
    // offset[6]=c[5], offset[5:3]=c[12:10], offset[2]=c[6]
    assign mem_off = {5'b0, half_i[5], half_i[12:10], half_i[6], 2'b00};

    // offset[11|4|9:8|10|6|7|3:1|5] sits in c[12:2]
    assign j_off = {{9{half_i[12]}}, half_i[12], half_i[8], half_i[10:9],
                    half_i[6], half_i[7], half_i[2], half_i[11],
                    half_i[5:3], 1'b0};

    always_comb begin
        // anything not decoded below is an illegal instruction
        inst_o = '0;
        // select on funct3 and quadrant
        case ({half_i[15:13], half_i[1:0]})
            // c.lw -> lw rd', off(rs1')
            5'b010_00: begin
                inst_o = {mem_off, rs1_prime, 3'b010, rd_prime, 7'b0000011};
            end
            // c.sw -> sw rs2', off(rs1')
            5'b110_00: begin
                inst_o = {mem_off[11:5], rd_prime, rs1_prime, 3'b010,
                          mem_off[4:0], 7'b0100011};
            end
            // c.addi -> addi rd, rd, imm
            // c.nop lands here with rd = x0 and imm = 0
            5'b000_01: begin
                inst_o = {ci_imm, rd_full, 3'b000, rd_full, 7'b0010011};
            end
            // c.li -> addi rd, x0, imm
            5'b010_01: begin
                inst_o = {ci_imm, 5'd0, 3'b000, rd_full, 7'b0010011};
            end
            // c.j -> jal x0, off
            5'b101_01: begin
                inst_o = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                          5'd0, 7'b1101111};
            end
            // c.mv / c.add
            // rs2 = x0 would be c.jr, c.jalr or c.ebreak, left illegal here
            5'b100_10: begin
                if (rs2_full != 5'd0) begin
                    if (half_i[12]) begin
                        // add rd, rd, rs2
                        inst_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, 7'b0110011};
                    end else begin
                        // add rd, x0, rs2
                        inst_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, 7'b0110011};
                    end
                end
            end
            default: begin
                inst_o = '0;
            end
        endcase
    end

endmodule

// File: fetch_aligner.sv
`timescale 1ns/10ps
`include "ifu_defines.svh"

module fetch_aligner (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`IFU_XLEN-1:0]      pc_i,
    input  ifu_types_pkg::imem_rsp_t  imem_rsp_i,
    input  logic                      flush_i,
    output ifu_types_pkg::fetch_out_t fetch_o,
    output logic                      inst_valid_o
);

    import ifu_types_pkg::*;

    // parcel addressed by pc[1]
    logic [`IFU_HALF-1:0]   cur_half;
    logic                   cur_is_c;
    logic [`IFU_XLEN-1:0]   expanded;

    // low half of a 32-bit instruction that spans two words
    logic                   buf_valid;
    logic [`IFU_HALF-1:0]   buf_half;
    // word index of the pc that filled the buffer
    logic [`IFU_XLEN-3:0]   buf_word;
    logic [`IFU_XLEN-3:0]   next_word;

    // strobe decisions
    logic                   save_half;
    logic                   join_hit;

    fetch_out_t             sel;
    logic                   sel_valid;

    assign cur_half = pc_i[1] ? imem_rsp_i.rdata[`IFU_XLEN-1:`IFU_HALF]
                              : imem_rsp_i.rdata[`IFU_HALF-1:0];
    // 2'b11 marks a 32-bit encoding
    assign cur_is_c = (cur_half[1:0] != 2'b11);

    assign next_word = buf_word + {{(`IFU_XLEN-3){1'b0}}, 1'b1};

    // upper half must come from the very next word
    assign join_hit = buf_valid && imem_rsp_i.valid
                      && (pc_i[`IFU_XLEN-1:2] == next_word);

    // 32-bit instruction starting at pc[1]=1 with nothing pending
    assign save_half = !buf_valid && imem_rsp_i.valid && !cur_is_c && pc_i[1];

    rvc_expander u_rvc_expander (
        .half_i (cur_half),
        .inst_o (expanded)
    );

    // buffer occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (flush_i) begin
            buf_valid <= 1'b0;
        end else if (save_half) begin
            buf_valid <= 1'b1;
        end else if (join_hit) begin
            buf_valid <= 1'b0;
        end
    end

    // saved parcel and its word index
    always_ff @(posedge clk) begin
        if (save_half) begin
            buf_half <= cur_half;
            buf_word <= pc_i[`IFU_XLEN-1:2];
        end
    end

    always_comb begin
        sel.addr          = pc_i;
        sel.inst          = `IFU_NOP;
        sel.is_compressed = 1'b0;
        sel_valid         = 1'b0;
        if (buf_valid) begin
            // new low half goes above the saved one
            // a non-sequential word keeps the buffer and gives nop
            if (join_hit) begin
                sel.inst  = {imem_rsp_i.rdata[`IFU_HALF-1:0], buf_half};
                sel_valid = 1'b1;
            end
        end else if (imem_rsp_i.valid) begin
            if (cur_is_c) begin
                sel.inst          = expanded;
                sel.is_compressed = 1'b1;
                sel_valid         = 1'b1;
            end else if (!pc_i[1]) begin
                // aligned 32-bit word
                sel.inst  = imem_rsp_i.rdata;
                sel_valid = 1'b1;
            end
            // otherwise the half is being saved, nop this cycle
        end
    end

    assign fetch_o      = sel;
    assign inst_valid_o = sel_valid;

endmodule

// File: fetch_translate_ctrl.sv
`timescale 1ns/10ps
`include "ifu_defines.svh"

module fetch_translate_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     xlat_en_i,
    input  ifu_types_pkg::xlat_rsp_t xlat_rsp_i,
    input  logic                     imem_valid_i,
    input  logic                     flush_i,
    input  logic                     ls_valid_i,
    output logic                     stall_o,
    output ifu_trap_pkg::trap_bus_t  trap_o
);

    import ifu_types_pkg::*;
    import ifu_trap_pkg::*;

    xlat_state_e state_q;
    xlat_state_e state_d;
    // faulting translation seen this cycle
    logic        page_fault;

    assign page_fault = xlat_rsp_i.valid && xlat_rsp_i.page_fault;

    always_comb begin
        state_d = state_q;
        case (state_q)
            XLAT_IDLE: begin
                if (xlat_en_i) begin
                    state_d = XLAT_WAIT_XLAT;
                end
            end
            XLAT_WAIT_XLAT: begin
                // a fault ends the sequence, the trap goes out this cycle
                if (xlat_rsp_i.valid) begin
                    state_d = xlat_rsp_i.page_fault ? XLAT_IDLE : XLAT_WAIT_MEM;
                end
            end
            XLAT_WAIT_MEM: begin
                if (imem_valid_i) begin
                    state_d = XLAT_IDLE;
                end
            end
            default: begin
                state_d = XLAT_IDLE;
            end
        endcase
        // redirect drops whatever was outstanding
        if (flush_i) begin
            state_d = XLAT_IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= XLAT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // load/store owns the memory port, never stall against it
    assign stall_o = !ls_valid_i && (!imem_valid_i || (state_q != XLAT_IDLE));

    always_comb begin
        // misaligned and access faults are not detected in fetch
        trap_o = '0;
        trap_o[CAUSE_INST_PAGE_FAULT] = page_fault;
    end

endmodule

// File: ifu.sv
`timescale 1ns/10ps
`include "ifu_defines.svh"

module ifu (
    input  logic                      clk,
    input  logic                      rst,
    // fetch pc from the pc stage
    input  logic [`IFU_XLEN-1:0]      inst_addr_i,
    input  ifu_types_pkg::imem_rsp_t  imem_rsp_i,
    // translation
    input  logic                      xlat_en_i,
    input  ifu_types_pkg::xlat_rsp_t  xlat_rsp_i,
    // pipeline control
    input  logic                      flush_i,
    input  logic                      ls_valid_i,
    // toward decode
    output ifu_types_pkg::fetch_out_t fetch_o,
    output logic                      inst_valid_o,
    // toward the pc stage
    output logic                      stall_o,
    output ifu_trap_pkg::trap_bus_t   trap_o
);

    import ifu_types_pkg::*;
    import ifu_trap_pkg::*;

    // aligned instruction and trap cause from the two halves
    fetch_out_t aligned;
    trap_bus_t  fetch_trap;

    // parcel alignment and rvc expansion
    fetch_aligner u_fetch_aligner (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (inst_addr_i),
        .imem_rsp_i   (imem_rsp_i),
        .flush_i      (flush_i),
        .fetch_o      (aligned),
        .inst_valid_o (inst_valid_o)
    );

    // translation wait, stall and page fault
    fetch_translate_ctrl u_fetch_translate_ctrl (
        .clk          (clk),
        .rst          (rst),
        .xlat_en_i    (xlat_en_i),
        .xlat_rsp_i   (xlat_rsp_i),
        .imem_valid_i (imem_rsp_i.valid),
        .flush_i      (flush_i),
        .ls_valid_i   (ls_valid_i),
        .stall_o      (stall_o),
        .trap_o       (fetch_trap)
    );

    assign fetch_o = aligned;
    assign trap_o  = fetch_trap;

endmodule

// File: tb_ifu.sv
`timescale 1ns/10ps
`include "ifu_defines.svh"

module tb_ifu;

    import ifu_types_pkg::*;

    // sample 1 ns before the rising edge
    localparam int sample_delay = 9;
    localparam int wait_limit   = 20;

    // one table row of stimulus
    typedef struct packed {
        logic [`IFU_XLEN-1:0] pc;
        logic                 imem_valid;
        logic [`IFU_XLEN-1:0] rdata;
        logic                 xlat_en;
        logic                 xlat_valid;
        logic                 fault;
        logic                 flush;
        logic                 ls_valid;
        // translation outstanding, idle a few cycles before the row
        logic                 hold;
    } stim_t;

    // expected responses for the same row
    typedef struct packed {
        logic [`IFU_XLEN-1:0] inst;
        logic                 valid;
        logic                 compressed;
        logic                 stall;
        logic                 page_fault;
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic [`IFU_XLEN-1:0]    inst_addr;
    imem_rsp_t               imem_rsp;
    logic                    xlat_en;
    xlat_rsp_t               xlat_rsp;
    logic                    flush;
    logic                    ls_valid;
    fetch_out_t              fetch;
    logic                    inst_valid;
    logic                    stall;
    ifu_trap_pkg::trap_bus_t trap;

    stim_t   stim_q[$];
    expect_t expect_q[$];
    int      errors;
    int      checks;
    int      row_idx;
    logic    timed_out;

    ifu u_ifu (
        .clk          (clk),
        .rst          (rst),
        .inst_addr_i  (inst_addr),
        .imem_rsp_i   (imem_rsp),
        .xlat_en_i    (xlat_en),
        .xlat_rsp_i   (xlat_rsp),
        .flush_i      (flush),
        .ls_valid_i   (ls_valid),
        .fetch_o      (fetch),
        .inst_valid_o (inst_valid),
        .stall_o      (stall),
        .trap_o       (trap)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED row %0d %s: got 0x%h, expected 0x%h",
                     row_idx, name, actual, expected);
        end
    endtask

    task automatic check_outputs(input logic [`IFU_XLEN-1:0] pc, input expect_t want);
        logic [`IFU_TRAP_LEN-1:0] want_trap;
        // only the page fault bit can ever be set
        want_trap = '0;
        want_trap[`IFU_TRAP_INST_PAGE_FAULT] = want.page_fault;
        check_value("fetch_o.addr", fetch.addr, pc);
        check_value("fetch_o.inst", fetch.inst, want.inst);
        check_value("inst_valid_o", 32'(inst_valid), 32'(want.valid));
        check_value("fetch_o.is_compressed", 32'(fetch.is_compressed), 32'(want.compressed));
        check_value("stall_o", 32'(stall), 32'(want.stall));
        check_value("trap_o", 32'(trap), 32'(want_trap));
    endtask

    task automatic drive(input stim_t s);
        inst_addr           = s.pc;
        imem_rsp.valid      = s.imem_valid;
        imem_rsp.rdata      = s.rdata;
        xlat_en             = s.xlat_en;
        xlat_rsp.valid      = s.xlat_valid;
        xlat_rsp.page_fault = s.fault;
        flush               = s.flush;
        ls_valid            = s.ls_valid;
    endtask

    // sequencer waiting on a strobe, stall must stay up for a random gap
    task automatic hold_translation(input stim_t row);
        stim_t   idle;
        expect_t want;
        int      extra;
        int      cycles;
        idle         = '0;
        idle.pc      = row.pc;
        idle.xlat_en = 1'b1;
        want         = '0;
        want.inst    = `IFU_NOP;
        want.stall   = 1'b1;
        if (row.xlat_valid) begin
            // translation pending, a c.nop word still arrives and is consumed
            // stall can only come from the sequencer state here
            idle.imem_valid = 1'b1;
            idle.rdata      = 32'h00000001;
            want.inst       = 32'h00000013;
            want.valid      = 1'b1;
            want.compressed = 1'b1;
        end
        extra        = $urandom_range(3, 0);
        cycles       = 0;
        do begin
            @(negedge clk);
            drive(idle);
            #sample_delay;
            check_outputs(row.pc, want);
            cycles++;
        end while ((stall !== 1'b1 || cycles <= extra) && cycles < wait_limit);
        if (stall !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout at row %0d: stall_o never rose while a translation was pending",
                     row_idx);
        end
    endtask

    task automatic add_row(input stim_t s, input expect_t e);
        stim_q.push_back(s);
        expect_q.push_back(e);
    endtask

    task automatic load_table();
        // aligned 32-bit word, addi x1, x0, 10
        add_row(stim_t'{32'h100, 1'b1, 32'h00a00093, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00a00093, 1'b1, 1'b0, 1'b0, 1'b0});
        // c.addi x1, 5 then c.addi x2, -1
        add_row(stim_t'{32'h104, 1'b1, 32'hffff0095, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00508093, 1'b1, 1'b1, 1'b0, 1'b0});
        add_row(stim_t'{32'h106, 1'b1, 32'h117d0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'hfff10113, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.nop
        add_row(stim_t'{32'h108, 1'b1, 32'h00000001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00000013, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.li x10, -3
        add_row(stim_t'{32'h10a, 1'b1, 32'h5575aaaa, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'hffd00513, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.lw x10, 68(x11) and c.sw x12, 40(x13)
        add_row(stim_t'{32'h10c, 1'b1, 32'h000041e8, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h0445a503, 1'b1, 1'b1, 1'b0, 1'b0});
        add_row(stim_t'{32'h10e, 1'b1, 32'hd6901234, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h02c6a423, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.j +102 and c.j -2
        add_row(stim_t'{32'h110, 1'b1, 32'h0000a09d, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h0660006f, 1'b1, 1'b1, 1'b0, 1'b0});
        add_row(stim_t'{32'h112, 1'b1, 32'hbffd0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'hfffff06f, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.mv x5, x6 and c.add x7, x8
        add_row(stim_t'{32'h114, 1'b1, 32'h0000829a, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h006002b3, 1'b1, 1'b1, 1'b0, 1'b0});
        add_row(stim_t'{32'h116, 1'b1, 32'h93a20000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h008383b3, 1'b1, 1'b1, 1'b0, 1'b0});
        // c.jr and the all-zero parcel are outside the subset
        add_row(stim_t'{32'h118, 1'b1, 32'h00008082, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00000000, 1'b1, 1'b1, 1'b0, 1'b0});
        add_row(stim_t'{32'h11a, 1'b1, 32'h00000000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00000000, 1'b1, 1'b1, 1'b0, 1'b0});
        // add x10, x11, x12 split over two words
        add_row(stim_t'{32'h202, 1'b1, 32'h85330001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b0, 1'b0});
        add_row(stim_t'{32'h204, 1'b1, 32'h123400c5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00c58533, 1'b1, 1'b0, 1'b0, 1'b0});
        // split start, then a jump away, then a flush
        add_row(stim_t'{32'h302, 1'b1, 32'h85330001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b0, 1'b0});
        add_row(stim_t'{32'h30c, 1'b1, 32'h123400c5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b0, 1'b0});
        add_row(stim_t'{32'h304, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b0});
        // buffer gone, the next word passes through on its own
        add_row(stim_t'{32'h304, 1'b1, 32'h00a00093, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00a00093, 1'b1, 1'b0, 1'b0, 1'b0});
        // no fetch word, then load/store priority
        add_row(stim_t'{32'h308, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b0});
        add_row(stim_t'{32'h308, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b0, 1'b0});
        // translation without fault
        add_row(stim_t'{32'h400, 1'b0, 32'h00000000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b0});
        add_row(stim_t'{32'h400, 1'b0, 32'h00000000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b0});
        add_row(stim_t'{32'h400, 1'b0, 32'h00000000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b0, 1'b0});
        // word arrives, stall holds one last cycle
        add_row(stim_t'{32'h400, 1'b1, 32'h00a00093, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
                expect_t'{32'h00a00093, 1'b1, 1'b0, 1'b1, 1'b0});
        add_row(stim_t'{32'h404, 1'b1, 32'h00000095, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00508093, 1'b1, 1'b1, 1'b0, 1'b0});
        // translation ending in a page fault
        add_row(stim_t'{32'h500, 1'b0, 32'h00000000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b0});
        add_row(stim_t'{32'h500, 1'b0, 32'h00000000, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1},
                expect_t'{`IFU_NOP, 1'b0, 1'b0, 1'b1, 1'b1});
        // fault flag without its strobe is ignored
        add_row(stim_t'{32'h500, 1'b1, 32'h00a00093, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
                expect_t'{32'h00a00093, 1'b1, 1'b0, 1'b0, 1'b0});
    endtask

    initial begin
        void'($urandom(32'd12));
        clk       = 1'b0;
        rst       = 1'b1;
        errors    = 0;
        checks    = 0;
        row_idx   = 0;
        timed_out = 1'b0;
        drive('0);
        load_table();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < stim_q.size(); i++) begin
            row_idx = i;
            if (stim_q[i].hold) begin
                hold_translation(stim_q[i]);
            end
            if (timed_out) begin
                break;
            end
            @(negedge clk);
            drive(stim_q[i]);
            #sample_delay;
            check_outputs(stim_q[i].pc, expect_q[i]);
        end

        @(negedge clk);
        drive('0);
        $display("rows: %0d, checks: %0d, errors: %0d", stim_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: ifu.f
+incdir+.
ifu_types_pkg.sv
ifu_trap_pkg.sv
rvc_expander.sv
fetch_aligner.sv
fetch_translate_ctrl.sv
ifu.sv
tb_ifu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_ifu
RTL_TOP    := ifu
FILELIST   := ifu.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --timescale 1ns/10ps -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/10ps
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
